// ==== design/ctrl_settings.svh ====
`ifndef CTRL_SETTINGS_SVH
`define CTRL_SETTINGS_SVH

// Instruction word layout
`define CTRL_INST_W 16
`define CTRL_OPCODE_W 5

// Register specifier and funct field widths
`define CTRL_REG_W 3
`define CTRL_FUNCT_W 2

// ALU operation code
`define CTRL_ALU_OP_W 4

// Cycles from instValid to ctrlValid, one per stage
`define CTRL_PIPE_DEPTH 2

`endif

// ==== design/isaPkg.sv ====
`default_nettype none

`include "ctrl_settings.svh"

package isaPkg;

    typedef enum logic [`CTRL_OPCODE_W-1:0] {
        HALT   = 5'b00000,
        NOP    = 5'b00001,
        ILL_OP = 5'b00010,
        RTI    = 5'b00011,
        J      = 5'b00100,  // PC-relative displacement
        JR     = 5'b00101,
        JAL    = 5'b00110,
        JALR   = 5'b00111,
        ADDI   = 5'b01000,
        SUBI   = 5'b01001,
        XORI   = 5'b01010,
        ANDNI  = 5'b01011,
        BEQZ   = 5'b01100,
        BNEZ   = 5'b01101,
        BLTZ   = 5'b01110,
        BGEZ   = 5'b01111,
        ST     = 5'b10000,
        LD     = 5'b10001,
        SLBI   = 5'b10010,
        STU    = 5'b10011,
        ROLI   = 5'b10100,
        SLLI   = 5'b10101,
        RORI   = 5'b10110,
        SRLI   = 5'b10111,
        LBI    = 5'b11000,
        BTR    = 5'b11001,
        S_ALU  = 5'b11010,  // Shift group, funct picks the op
        B_ALU  = 5'b11011,  // Arith group, funct picks the op
        SEQ    = 5'b11100,
        SLT    = 5'b11101,
        SLE    = 5'b11110,
        SCO    = 5'b11111
    } opcode_e;

    typedef enum logic [`CTRL_FUNCT_W-1:0] {
        ADD  = 2'b00,
        SUB  = 2'b01,
        XOR  = 2'b10,
        ANDN = 2'b11
    } aluFunct_e;

    typedef enum logic [`CTRL_FUNCT_W-1:0] {
        ROL = 2'b00,
        SLL = 2'b01,
        ROR = 2'b10,
        SRL = 2'b11
    } shiftFunct_e;

    typedef struct packed {
        opcode_e                  opcode;
        logic [`CTRL_REG_W-1:0]   rs;     // inst[10:8]
        logic [`CTRL_REG_W-1:0]   rt;     // inst[7:5]
        logic [`CTRL_REG_W-1:0]   rd;     // inst[4:2]
        logic [`CTRL_FUNCT_W-1:0] funct;
    } rFmt_t;

    typedef struct packed {
        opcode_e                                       opcode;
        logic [`CTRL_REG_W-1:0]                        rs;
        logic [`CTRL_INST_W-`CTRL_OPCODE_W-`CTRL_REG_W-1:0] imm;
    } iFmt_t;

    // Same 16 bits, read as register or immediate format
    typedef union packed {
        rFmt_t rFmt;
        iFmt_t iFmt;
    } instWord_u;

endpackage

`default_nettype wire

// ==== design/ctrlPkg.sv ====
`default_nettype none

`include "ctrl_settings.svh"

package ctrlPkg;

    typedef enum logic [`CTRL_ALU_OP_W-1:0] {
        ALU_ROL  = 4'b0000,
        ALU_SLL  = 4'b0001,
        ALU_ROR  = 4'b0010,
        ALU_SRL  = 4'b0011,
        ALU_ADD  = 4'b0100,
        ALU_ANDN = 4'b0101,
        ALU_PASS = 4'b0110,
        ALU_XOR  = 4'b0111,
        ALU_SLBI = 4'b1000,
        ALU_SUB  = 4'b1001,
        ALU_SEQ  = 4'b1010,
        ALU_SLT  = 4'b1011,
        ALU_SLE  = 4'b1100,
        ALU_SCO  = 4'b1101,
        ALU_BTR  = 4'b1110,
        ALU_LBI  = 4'b1111
    } aluOp_e;

    typedef enum logic [1:0] {HOLD, INCR, TARGET, EPC} pcSrc_e;

    // Which instruction field names the destination
    typedef enum logic [1:0] {RD_LOW, RD_MID, RD_HIGH, R7} dstSel_e;

    typedef enum logic [1:0] {IMM5, IMM8, DISP11} extOp_e;

    typedef enum logic [2:0] {
        BJ_BEQZ, BJ_BNEZ, BJ_BLTZ, BJ_BGEZ,
        BJ_J, BJ_JR, BJ_JAL, BJ_JALR
    } bjOp_e;

    typedef enum logic [1:0] {FIXED, ARITH_FUNCT, SHIFT_FUNCT} aluClass_e;

    typedef struct packed {
        aluOp_e aluOp;
        logic   invR1;
        logic   invR2;
        logic   cin;
        logic   sign;
    } aluCtrl_t;

    typedef struct packed {
        aluCtrl_t alu;
        pcSrc_e   pcSrc;
        dstSel_e  dstSel;
        extOp_e   extOp;
        logic     extSign;    // 1 sign extend, 0 zero extend
        logic     aluSrcImm;  // Operand B from the immediate
        logic     regWrite;
        logic     jump;
        logic     branch;
        bjOp_e    bjOp;
        logic     memWrite;
        logic     memToReg;
        logic     memEn;
        logic     link;       // Write PC instead of ALU result
        logic     excp;
    } ctrlWord_t;

    typedef struct packed {
        pcSrc_e                   pcSrc;
        dstSel_e                  dstSel;
        extOp_e                   extOp;
        logic                     extSign;
        logic                     aluSrcImm;
        logic                     regWrite;
        logic                     jump;
        logic                     branch;
        bjOp_e                    bjOp;
        logic                     memWrite;
        logic                     memToReg;
        logic                     memEn;
        logic                     link;
        logic                     excp;
        aluClass_e                aluClass;
        aluCtrl_t                 fixedAlu;  // Only meaningful for FIXED
        logic [`CTRL_FUNCT_W-1:0] funct;
    } opDecode_t;

endpackage

`default_nettype wire

// ==== design/opcodeStage.sv ====
`default_nettype none

module opcodeStage (
    input  wire                clk,
    input  wire                rstN,
    input  wire                instValid,
    input  wire isaPkg::instWord_u inst,
    output logic               opValid,
    output ctrlPkg::opDecode_t opDec
);

    // ALU controls for opcodes that do not look at funct
    function automatic ctrlPkg::aluCtrl_t fixedAluOf(input isaPkg::opcode_e op);
        ctrlPkg::aluCtrl_t a;
        a = '0;  // ROL with all flags clear
        case (op)
            isaPkg::ADDI, isaPkg::ST, isaPkg::LD, isaPkg::STU:
                a = '{ctrlPkg::ALU_ADD, 1'b0, 1'b0, 1'b0, 1'b1};
            isaPkg::SUBI:  a = '{ctrlPkg::ALU_SUB, 1'b1, 1'b0, 1'b1, 1'b1};
            isaPkg::XORI:  a = '{ctrlPkg::ALU_XOR, 1'b0, 1'b0, 1'b0, 1'b0};
            isaPkg::ANDNI: a = '{ctrlPkg::ALU_ANDN, 1'b0, 1'b1, 1'b0, 1'b0};
            isaPkg::SLLI:  a = '{ctrlPkg::ALU_SLL, 1'b0, 1'b0, 1'b0, 1'b0};
            isaPkg::RORI:  a = '{ctrlPkg::ALU_ROR, 1'b0, 1'b0, 1'b0, 1'b0};
            isaPkg::SRLI:  a = '{ctrlPkg::ALU_SRL, 1'b0, 1'b0, 1'b0, 1'b0};
            isaPkg::BTR:   a = '{ctrlPkg::ALU_BTR, 1'b0, 1'b0, 1'b0, 1'b0};
            // Compares subtract B from A
            isaPkg::SEQ:   a = '{ctrlPkg::ALU_SEQ, 1'b0, 1'b1, 1'b1, 1'b1};
            isaPkg::SLT:   a = '{ctrlPkg::ALU_SLT, 1'b0, 1'b1, 1'b1, 1'b1};
            isaPkg::SLE:   a = '{ctrlPkg::ALU_SLE, 1'b0, 1'b1, 1'b1, 1'b1};
            isaPkg::SCO:   a = '{ctrlPkg::ALU_SCO, 1'b0, 1'b0, 1'b0, 1'b1};
            isaPkg::LBI:   a = '{ctrlPkg::ALU_LBI, 1'b0, 1'b0, 1'b0, 1'b0};
            isaPkg::SLBI:  a = '{ctrlPkg::ALU_SLBI, 1'b0, 1'b0, 1'b0, 1'b0};
            default: ;
        endcase
        return a;
    endfunction

    logic [4:0]         opBits;
    ctrlPkg::opDecode_t decNext;

    assign opBits = inst.rFmt.opcode;

    always_comb begin
        decNext          = '0;
        decNext.pcSrc    = ctrlPkg::INCR;
        decNext.memEn    = 1'b1;
        decNext.aluClass = ctrlPkg::FIXED;
        decNext.fixedAlu = fixedAluOf(inst.rFmt.opcode);
        case (inst.rFmt.opcode)
            isaPkg::HALT: begin
                decNext.pcSrc = ctrlPkg::HOLD;
                decNext.memEn = 1'b0;
            end
            isaPkg::NOP: decNext.memEn = 1'b0;
            isaPkg::ILL_OP: begin
                decNext.pcSrc = ctrlPkg::EPC;
                decNext.excp  = 1'b1;
            end
            isaPkg::RTI: decNext.pcSrc = ctrlPkg::EPC;
            isaPkg::J, isaPkg::JR, isaPkg::JAL, isaPkg::JALR: begin
                decNext.pcSrc   = ctrlPkg::TARGET;
                decNext.extSign = 1'b1;
                decNext.jump    = 1'b1;
                decNext.bjOp    = ctrlPkg::bjOp_e'({1'b1, opBits[1:0]});
                // Odd opcodes are register-relative with an imm8
                decNext.extOp   = opBits[0] ? ctrlPkg::IMM8 : ctrlPkg::DISP11;
                if (opBits[1]) begin  // Linking forms write R7
                    decNext.dstSel   = ctrlPkg::R7;
                    decNext.regWrite = 1'b1;
                    decNext.link     = 1'b1;
                end
            end
            isaPkg::BEQZ, isaPkg::BNEZ, isaPkg::BLTZ, isaPkg::BGEZ: begin
                decNext.pcSrc   = ctrlPkg::TARGET;
                decNext.extOp   = ctrlPkg::IMM8;
                decNext.extSign = 1'b1;
                decNext.branch  = 1'b1;
                decNext.bjOp    = ctrlPkg::bjOp_e'({1'b0, opBits[1:0]});
            end
            isaPkg::ADDI, isaPkg::SUBI, isaPkg::ST, isaPkg::LD, isaPkg::STU: begin
                decNext.dstSel    = ctrlPkg::RD_MID;
                decNext.aluSrcImm = 1'b1;
                decNext.extSign   = 1'b1;
                decNext.regWrite  = (inst.rFmt.opcode != isaPkg::ST);
                decNext.memWrite  = (inst.rFmt.opcode == isaPkg::ST) ||
                                    (inst.rFmt.opcode == isaPkg::STU);
                decNext.memToReg  = (inst.rFmt.opcode == isaPkg::LD);
            end
            isaPkg::XORI, isaPkg::ANDNI, isaPkg::ROLI, isaPkg::SLLI,
            isaPkg::RORI, isaPkg::SRLI: begin
                decNext.dstSel    = ctrlPkg::RD_MID;
                decNext.aluSrcImm = 1'b1;
                decNext.regWrite  = 1'b1;
            end
            isaPkg::LBI, isaPkg::SLBI: begin
                decNext.dstSel    = ctrlPkg::RD_HIGH;
                decNext.extOp     = ctrlPkg::IMM8;
                decNext.extSign   = 1'b1;
                decNext.aluSrcImm = 1'b1;
                decNext.regWrite  = 1'b1;
            end
            isaPkg::BTR, isaPkg::SEQ, isaPkg::SLT, isaPkg::SLE, isaPkg::SCO:
                decNext.regWrite = 1'b1;
            isaPkg::B_ALU, isaPkg::S_ALU: begin
                decNext.regWrite = 1'b1;
                decNext.aluClass = (inst.rFmt.opcode == isaPkg::B_ALU) ?
                                   ctrlPkg::ARITH_FUNCT : ctrlPkg::SHIFT_FUNCT;
                decNext.funct    = inst.rFmt.funct;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            opValid <= 1'b0;
            opDec   <= '0;
        end else begin
            opValid <= instValid;
            if (instValid)
                opDec <= decNext;
        end
    end

endmodule

`default_nettype wire

// ==== design/aluCtrlStage.sv ====
`default_nettype none

module aluCtrlStage (
    input  wire                     clk,
    input  wire                     rstN,
    input  wire                     opValid,
    input  wire ctrlPkg::opDecode_t opDec,
    output logic                    ctrlValid,
    output ctrlPkg::ctrlWord_t      ctrl
);

    ctrlPkg::aluCtrl_t  aluNext;
    ctrlPkg::ctrlWord_t ctrlNext;

    always_comb begin
        aluNext = opDec.fixedAlu;
        case (opDec.aluClass)
            ctrlPkg::ARITH_FUNCT: begin
                case (opDec.funct)  // All signed
                    2'b00: aluNext = '{ctrlPkg::ALU_ADD, 1'b0, 1'b0, 1'b0, 1'b1};
                    2'b01: aluNext = '{ctrlPkg::ALU_SUB, 1'b1, 1'b0, 1'b1, 1'b1};
                    2'b10: aluNext = '{ctrlPkg::ALU_XOR, 1'b0, 1'b0, 1'b0, 1'b1};
                    2'b11: aluNext = '{ctrlPkg::ALU_ANDN, 1'b0, 1'b1, 1'b0, 1'b1};
                endcase
            end
            ctrlPkg::SHIFT_FUNCT: begin
                case (opDec.funct)
                    2'b00: aluNext = '{ctrlPkg::ALU_ROL, 1'b0, 1'b0, 1'b0, 1'b0};
                    2'b01: aluNext = '{ctrlPkg::ALU_SLL, 1'b0, 1'b0, 1'b0, 1'b0};
                    2'b10: aluNext = '{ctrlPkg::ALU_ROR, 1'b0, 1'b0, 1'b0, 1'b0};
                    2'b11: aluNext = '{ctrlPkg::ALU_SRL, 1'b0, 1'b0, 1'b0, 1'b0};
                endcase
            end
            default: ;  // FIXED keeps stage one result
        endcase
    end

    // Opcode-level fields pass straight across
    always_comb begin
        ctrlNext.alu       = aluNext;
        ctrlNext.pcSrc     = opDec.pcSrc;
        ctrlNext.dstSel    = opDec.dstSel;
        ctrlNext.extOp     = opDec.extOp;
        ctrlNext.extSign   = opDec.extSign;
        ctrlNext.aluSrcImm = opDec.aluSrcImm;
        ctrlNext.regWrite  = opDec.regWrite;
        ctrlNext.jump      = opDec.jump;
        ctrlNext.branch    = opDec.branch;
        ctrlNext.bjOp      = opDec.bjOp;
        ctrlNext.memWrite  = opDec.memWrite;
        ctrlNext.memToReg  = opDec.memToReg;
        ctrlNext.memEn     = opDec.memEn;
        ctrlNext.link      = opDec.link;
        ctrlNext.excp      = opDec.excp;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ctrlValid <= 1'b0;
            ctrl      <= '0;
        end else begin
            ctrlValid <= opValid;
            if (opValid)
                ctrl <= ctrlNext;
        end
    end

endmodule

`default_nettype wire

// ==== design/ctrlDecoder.sv ====
`default_nettype none

module ctrlDecoder (
    input  wire                     clk,
    input  wire                     rstN,
    input  wire                     instValid,
    input  wire isaPkg::instWord_u  inst,
    output wire                     ctrlValid,
    output wire ctrlPkg::ctrlWord_t ctrl
);

    wire                     opValid;
    wire ctrlPkg::opDecode_t opDec;

    // Stage 1, opcode table
    opcodeStage u_opcodeStage (
        .clk       (clk),
        .rstN      (rstN),
        .instValid (instValid),
        .inst      (inst),
        .opValid   (opValid),
        .opDec     (opDec)
    );

    // Stage 2, funct-level ALU select
    aluCtrlStage u_aluCtrlStage (
        .clk       (clk),
        .rstN      (rstN),
        .opValid   (opValid),
        .opDec     (opDec),
        .ctrlValid (ctrlValid),
        .ctrl      (ctrl)
    );

endmodule

`default_nettype wire

// ==== dv/ctrlDecoderTb.sv ====
`default_nettype none

`include "ctrl_settings.svh"

module ctrlDecoderTb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int ResetCycles = 4;
    localparam int BurstLen    = 16;
    localparam int NumRandom   = 400;
    localparam int MaxGap      = 3;
    localparam int NumDirected = 12;
    localparam int StimCycles  = ResetCycles + 8 + BurstLen + NumRandom * (MaxGap + 1) +
                                 NumDirected * (`CTRL_PIPE_DEPTH + 2) + 8;
    localparam int CycleLimit  = StimCycles + 20;

    logic                clk;
    logic                rstN;
    logic                instValid;
    isaPkg::instWord_u   inst;
    logic                ctrlValid;
    ctrlPkg::ctrlWord_t  ctrl;

    integer              seed = 32'hedf5;
    int                  cycles = 0;
    int                  validErrors = 0;
    int                  ctrlErrors = 0;
    int                  otherErrors = 0;
    logic [`CTRL_PIPE_DEPTH-1:0] vHist;  // instValid history with the oldest at the top
    ctrlPkg::ctrlWord_t  expQ[$];
    ctrlPkg::ctrlWord_t  lastWord = '0;  // Zero out of reset
    ctrlPkg::ctrlWord_t  got;
    ctrlPkg::ctrlWord_t  exp;
    logic [31:0]         r;

    ctrlDecoder u_ctrlDecoder (
        .clk       (clk),
        .rstN      (rstN),
        .instValid (instValid),
        .inst      (inst),
        .ctrlValid (ctrlValid),
        .ctrl      (ctrl)
    );

    always #5 clk = ~clk;

    function automatic ctrlPkg::aluCtrl_t aluOf(input ctrlPkg::aluOp_e o, input bit r1,
                                                input bit r2, input bit c, input bit s);
        ctrlPkg::aluCtrl_t a;
        a.aluOp = o;
        a.invR1 = r1;
        a.invR2 = r2;
        a.cin   = c;
        a.sign  = s;
        return a;
    endfunction

    // Register ALU groups pick the op from funct
    function automatic ctrlPkg::aluCtrl_t functAlu(input bit shift, input logic [1:0] f);
        ctrlPkg::aluCtrl_t a;
        a = '0;
        if (shift) begin
            case (isaPkg::shiftFunct_e'(f))
                isaPkg::ROL: a = aluOf(ctrlPkg::ALU_ROL, 0, 0, 0, 0);
                isaPkg::SLL: a = aluOf(ctrlPkg::ALU_SLL, 0, 0, 0, 0);
                isaPkg::ROR: a = aluOf(ctrlPkg::ALU_ROR, 0, 0, 0, 0);
                isaPkg::SRL: a = aluOf(ctrlPkg::ALU_SRL, 0, 0, 0, 0);
            endcase
        end else begin
            case (isaPkg::aluFunct_e'(f))
                isaPkg::ADD:  a = aluOf(ctrlPkg::ALU_ADD, 0, 0, 0, 1);
                isaPkg::SUB:  a = aluOf(ctrlPkg::ALU_SUB, 1, 0, 1, 1);
                isaPkg::XOR:  a = aluOf(ctrlPkg::ALU_XOR, 0, 0, 0, 1);
                isaPkg::ANDN: a = aluOf(ctrlPkg::ALU_ANDN, 0, 1, 0, 1);
            endcase
        end
        return a;
    endfunction

    function automatic ctrlPkg::aluCtrl_t modelAlu(input isaPkg::opcode_e op,
                                                   input logic [1:0] f);
        ctrlPkg::aluCtrl_t a;
        a = aluOf(ctrlPkg::ALU_ROL, 0, 0, 0, 0);  // ROLI and non-ALU rows
        case (op)
            isaPkg::ADDI, isaPkg::ST, isaPkg::LD, isaPkg::STU:
                a = aluOf(ctrlPkg::ALU_ADD, 0, 0, 0, 1);
            isaPkg::SUBI:  a = aluOf(ctrlPkg::ALU_SUB, 1, 0, 1, 1);
            isaPkg::XORI:  a = aluOf(ctrlPkg::ALU_XOR, 0, 0, 0, 0);
            isaPkg::ANDNI: a = aluOf(ctrlPkg::ALU_ANDN, 0, 1, 0, 0);
            isaPkg::SLLI:  a = aluOf(ctrlPkg::ALU_SLL, 0, 0, 0, 0);
            isaPkg::RORI:  a = aluOf(ctrlPkg::ALU_ROR, 0, 0, 0, 0);
            isaPkg::SRLI:  a = aluOf(ctrlPkg::ALU_SRL, 0, 0, 0, 0);
            isaPkg::BTR:   a = aluOf(ctrlPkg::ALU_BTR, 0, 0, 0, 0);
            isaPkg::SEQ:   a = aluOf(ctrlPkg::ALU_SEQ, 0, 1, 1, 1);
            isaPkg::SLT:   a = aluOf(ctrlPkg::ALU_SLT, 0, 1, 1, 1);
            isaPkg::SLE:   a = aluOf(ctrlPkg::ALU_SLE, 0, 1, 1, 1);
            isaPkg::SCO:   a = aluOf(ctrlPkg::ALU_SCO, 0, 0, 0, 1);
            isaPkg::LBI:   a = aluOf(ctrlPkg::ALU_LBI, 0, 0, 0, 0);
            isaPkg::SLBI:  a = aluOf(ctrlPkg::ALU_SLBI, 0, 0, 0, 0);
            isaPkg::B_ALU: a = functAlu(1'b0, f);
            isaPkg::S_ALU: a = functAlu(1'b1, f);
            default: ;
        endcase
        return a;
    endfunction

    function automatic ctrlPkg::ctrlWord_t modelCtrl(input isaPkg::instWord_u i);
        ctrlPkg::ctrlWord_t w;
        isaPkg::opcode_e    op;
        op = i.iFmt.opcode;
        w = '0;
        w.alu   = modelAlu(op, i.rFmt.funct);
        w.pcSrc = ctrlPkg::INCR;
        w.memEn = !(op inside {isaPkg::HALT, isaPkg::NOP});
        case (op)
            isaPkg::HALT: w.pcSrc = ctrlPkg::HOLD;
            isaPkg::ILL_OP: begin
                w.pcSrc = ctrlPkg::EPC;
                w.excp  = 1'b1;
            end
            isaPkg::RTI: w.pcSrc = ctrlPkg::EPC;
            isaPkg::J, isaPkg::JR, isaPkg::JAL, isaPkg::JALR: begin
                w.pcSrc    = ctrlPkg::TARGET;
                w.jump     = 1'b1;
                w.extSign  = 1'b1;
                w.extOp    = (op inside {isaPkg::JR, isaPkg::JALR}) ? ctrlPkg::IMM8
                                                                   : ctrlPkg::DISP11;
                w.link     = op inside {isaPkg::JAL, isaPkg::JALR};
                w.regWrite = w.link;
                w.dstSel   = w.link ? ctrlPkg::R7 : ctrlPkg::RD_LOW;
                w.bjOp     = (op == isaPkg::J)   ? ctrlPkg::BJ_J :
                             (op == isaPkg::JR)  ? ctrlPkg::BJ_JR :
                             (op == isaPkg::JAL) ? ctrlPkg::BJ_JAL : ctrlPkg::BJ_JALR;
            end
            isaPkg::BEQZ, isaPkg::BNEZ, isaPkg::BLTZ, isaPkg::BGEZ: begin
                w.pcSrc   = ctrlPkg::TARGET;
                w.extOp   = ctrlPkg::IMM8;
                w.extSign = 1'b1;
                w.branch  = 1'b1;
                w.bjOp    = (op == isaPkg::BEQZ) ? ctrlPkg::BJ_BEQZ :
                            (op == isaPkg::BNEZ) ? ctrlPkg::BJ_BNEZ :
                            (op == isaPkg::BLTZ) ? ctrlPkg::BJ_BLTZ : ctrlPkg::BJ_BGEZ;
            end
            isaPkg::ADDI, isaPkg::SUBI, isaPkg::ST, isaPkg::LD, isaPkg::STU: begin
                w.dstSel    = ctrlPkg::RD_MID;
                w.aluSrcImm = 1'b1;
                w.extSign   = 1'b1;
                w.regWrite  = (op != isaPkg::ST);  // Plain store writes no register
                w.memWrite  = op inside {isaPkg::ST, isaPkg::STU};
                w.memToReg  = (op == isaPkg::LD);
            end
            isaPkg::XORI, isaPkg::ANDNI, isaPkg::ROLI, isaPkg::SLLI,
            isaPkg::RORI, isaPkg::SRLI: begin
                w.dstSel    = ctrlPkg::RD_MID;
                w.aluSrcImm = 1'b1;
                w.regWrite  = 1'b1;
            end
            isaPkg::LBI, isaPkg::SLBI: begin
                w.dstSel    = ctrlPkg::RD_HIGH;
                w.extOp     = ctrlPkg::IMM8;
                w.extSign   = 1'b1;
                w.aluSrcImm = 1'b1;
                w.regWrite  = 1'b1;
            end
            isaPkg::BTR, isaPkg::SEQ, isaPkg::SLT, isaPkg::SLE, isaPkg::SCO,
            isaPkg::B_ALU, isaPkg::S_ALU:
                w.regWrite = 1'b1;
            default: ;
        endcase
        return w;
    endfunction

    task automatic checkCtrl(input ctrlPkg::ctrlWord_t actual, input ctrlPkg::ctrlWord_t want,
                             input string what);
        if (actual !== want) begin
            ctrlErrors++;
            $display("** Error at %0t: %s ctrl %h, expected %h", $time, what, actual, want);
        end
    endtask

    task automatic checkValid(input logic actual, input logic want);
        if (actual !== want) begin
            validErrors++;
            $display("** Error at %0t: ctrlValid %b, expected %b", $time, actual, want);
        end
    endtask

    task automatic sendInst(input logic [15:0] bits);
        @(posedge clk);
        #1;
        instValid = 1'b1;
        inst      = bits;
    endtask

    // Junk on inst while invalid must not reach the output
    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            r         = $random(seed);
            instValid = 1'b0;
            inst      = r[15:0];
        end
    endtask

    task automatic decodeOne(input logic [15:0] bits, output ctrlPkg::ctrlWord_t word);
        sendInst(bits);
        idle(1);
        do @(negedge clk); while (!ctrlValid);
        word = ctrl;
    endtask

    // Expected words queued on the edge where the DUT samples instValid
    always @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            vHist <= '0;
            expQ.delete();
        end else begin
            vHist <= {vHist[`CTRL_PIPE_DEPTH-2:0], instValid};
            if (instValid)
                expQ.push_back(modelCtrl(inst));
        end
    end

    always @(negedge clk) begin
        checkValid(ctrlValid, vHist[`CTRL_PIPE_DEPTH-1]);
        if (vHist[`CTRL_PIPE_DEPTH-1]) begin
            if (expQ.size() == 0) begin
                otherErrors++;
                $display("Output at %0t has no matching input instruction", $time);
            end else begin
                lastWord = expQ.pop_front();
                checkCtrl(ctrl, lastWord, "model");
            end
        end else begin
            checkCtrl(ctrl, lastWord, "held");  // Stays put between valids
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CycleLimit) begin
            $display("timeout: simulation did not finish after %0d cycles", cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        clk       = 1'b0;
        rstN      = 1'b0;
        instValid = 1'b0;
        inst      = '0;
        repeat (ResetCycles) @(posedge clk);
        #1 rstN = 1'b1;
        idle(4);

        // Back-to-back burst
        for (int k = 0; k < BurstLen; k++) begin
            r = $random(seed);
            sendInst(r[15:0]);
        end
        idle(4);

        for (int k = 0; k < NumRandom; k++) begin
            r = $random(seed);
            sendInst(r[15:0]);
            r = $random(seed);
            idle(int'(r[1:0]));  // Zero gap keeps the run back to back
        end
        idle(4);

        for (int f = 0; f < 4; f++) begin
            decodeOne({isaPkg::B_ALU, 9'h0a5, f[1:0]}, got);
            exp = got;
            exp.alu = functAlu(1'b0, f[1:0]);
            checkCtrl(got, exp, "B_ALU funct");
            decodeOne({isaPkg::S_ALU, 9'h15a, f[1:0]}, got);
            exp = got;
            exp.alu = functAlu(1'b1, f[1:0]);
            checkCtrl(got, exp, "S_ALU funct");
        end

        decodeOne({isaPkg::ILL_OP, 11'h000}, got);
        exp = got;
        exp.excp  = 1'b1;
        exp.pcSrc = ctrlPkg::EPC;
        checkCtrl(got, exp, "ILL_OP");
        decodeOne({isaPkg::RTI, 11'h000}, got);
        exp = got;
        exp.excp  = 1'b0;
        exp.pcSrc = ctrlPkg::EPC;
        checkCtrl(got, exp, "RTI");
        decodeOne({isaPkg::HALT, 11'h000}, got);
        exp = got;
        exp.pcSrc = ctrlPkg::HOLD;
        exp.memEn = 1'b0;
        checkCtrl(got, exp, "HALT");
        decodeOne({isaPkg::NOP, 11'h000}, got);
        exp = got;
        exp.pcSrc    = ctrlPkg::INCR;
        exp.regWrite = 1'b0;
        exp.memWrite = 1'b0;
        checkCtrl(got, exp, "NOP");
        idle(4);

        if (expQ.size() != 0) begin
            otherErrors++;
            $display("%0d expected control words never came out", expQ.size());
        end
        $display("Error counts: valid %0d, ctrl %0d, other %0d",
                 validErrors, ctrlErrors, otherErrors);
        if (validErrors + ctrlErrors + otherErrors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== ctrlDecoder.f ====
+incdir+design
design/isaPkg.sv
design/ctrlPkg.sv
design/opcodeStage.sv
design/aluCtrlStage.sv
design/ctrlDecoder.sv
dv/ctrlDecoderTb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the ctrlDecoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
SIM=obj_dir/ctrlDecoderSim

verilator --binary --timing -f ctrlDecoder.f --top-module ctrlDecoderTb -o ctrlDecoderSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$SIM" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Done: errors found" "$LOG"; then
    echo "Simulation FAILED"
    exit 1
fi

echo "Simulation PASSED"
exit 0
